// File: rtl/icache_pkg.sv
// instruction cache package

`default_nettype none

package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////////////

  // fetch address and instruction word
  localparam int ADDR_W     = 32;
  localparam int FETCH_W    = 32;
  // one line holds four words
  localparam int LINE_W     = 128;
  localparam int NUM_WAYS   = 2;
  localparam int NUM_SETS   = 16;
  // address split: tag | index | word | byte
  localparam int OFFSET_W   = 4;
  localparam int INDEX_W    = 4;
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WORD_SEL_W = 2;
  // replacement lfsr
  localparam int LFSR_W     = 8;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0]               addr_t;
  typedef logic [TAG_W-1:0]                tag_t;
  typedef logic [INDEX_W-1:0]              index_t;
  typedef logic [WORD_SEL_W-1:0]           word_sel_t;
  typedef logic [FETCH_W-1:0]              fetch_word_t;
  typedef logic [LINE_W-1:0]               line_t;
  // one bit per way
  typedef logic [NUM_WAYS-1:0]             way_mask_t;
  // binary way number
  typedef logic [$clog2(NUM_WAYS)-1:0]     way_idx_t;

  // controller states, FLUSH is the reset state
  typedef enum logic [2:0] {
    FLUSH,
    IDLE,
    LOOKUP,
    REFILL
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/icache_ctrl.sv
// instruction cache controller

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // fetch side
  input  wire logic      req_valid_i,
  input  wire addr_t     req_addr_i,
  output logic           busy_o,
  output logic           rsp_valid_o,
  output logic           miss_o,
  // memory side
  output logic           mem_req_o,
  output addr_t          mem_addr_o,
  input  wire logic      mem_rtrn_valid_i,
  // maintenance
  input  wire logic      flush_i,
  input  wire logic      inv_valid_i,
  input  wire index_t    inv_index_i,
  // from hit stage and arrays
  input  wire logic      hit_i,
  input  wire way_mask_t vld_rdata_i,
  // to arrays
  output logic           rd_en_o,
  output logic           wr_en_o,
  output logic           vld_clr_en_o,
  output index_t         arr_index_o,
  output way_mask_t      wr_way_mask_o,
  output tag_t           wr_tag_o,
  // to hit stage
  output tag_t           lookup_tag_o,
  output word_sel_t      lookup_word_o,
  output logic           use_refill_o
);

  ctrl_state_e state_d, state_q;

  // registered fetch address of the lookup in flight
  addr_t       req_addr_q;
  index_t      lookup_index;

  // pending flush and set counter
  logic        flush_d, flush_q;
  index_t      flush_cnt_d, flush_cnt_q;
  logic        flush_last;

  // replacement
  way_idx_t    inv_way;
  logic        all_valid;
  way_idx_t    repl_way_q;
  logic        all_valid_q;
  logic        repl_capture;
  logic [LFSR_W-1:0] lfsr_q;
  logic        lfsr_fb;
  logic        lfsr_step;

  logic        can_accept;
  logic        accept;

  //////////////////////////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////////////////////////

  assign lookup_tag_o  = req_addr_q[ADDR_W-1 -: TAG_W];
  assign lookup_index  = req_addr_q[OFFSET_W +: INDEX_W];
  assign lookup_word_o = req_addr_q[OFFSET_W-1 -: WORD_SEL_W];

  // line request, offset bits forced to zero
  assign mem_addr_o = {req_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // tag goes along with the line write
  assign wr_tag_o = lookup_tag_o;

  // requests only in idle or right after a hit, never with a flush waiting
  assign can_accept = ~flush_q & ~flush_i &
                      ((state_q == IDLE) | ((state_q == LOOKUP) & hit_i));
  assign busy_o     = ~can_accept;
  assign accept     = req_valid_i & can_accept;

  assign use_refill_o = (state_q == REFILL);

  assign flush_last = (flush_cnt_q == index_t'(NUM_SETS - 1));

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    flush_d      = flush_q | flush_i;
    rd_en_o      = 1'b0;
    wr_en_o      = 1'b0;
    vld_clr_en_o = 1'b0;
    rsp_valid_o  = 1'b0;
    miss_o       = 1'b0;
    mem_req_o    = 1'b0;
    // read index comes straight from the fetch port
    arr_index_o  = req_addr_i[OFFSET_W +: INDEX_W];

    unique case (state_q)
      FLUSH: begin
        // clear one set per cycle
        vld_clr_en_o = 1'b1;
        arr_index_o  = flush_cnt_q;
        if (flush_last) begin
          state_d = IDLE;
          flush_d = 1'b0;
        end
      end
      IDLE: begin
        // flush wins, it clears the set of any invalidation anyway
        if (flush_d) begin
          state_d = FLUSH;
        end else if (inv_valid_i) begin
          vld_clr_en_o = 1'b1;
          arr_index_o  = inv_index_i;
        end else if (accept) begin
          rd_en_o = 1'b1;
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit_i) begin
          rsp_valid_o = 1'b1;
          // next lookup overlaps with this response
          if (accept) begin
            rd_en_o = 1'b1;
          end else begin
            state_d = IDLE;
          end
        end else begin
          mem_req_o = 1'b1;
          miss_o    = 1'b1;
          state_d   = REFILL;
        end
      end
      REFILL: begin
        arr_index_o = lookup_index;
        // returned line is forwarded and written in the same cycle
        if (mem_rtrn_valid_i) begin
          wr_en_o     = 1'b1;
          rsp_valid_o = 1'b1;
          state_d     = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  // counter restarts at zero whenever we leave FLUSH
  assign flush_cnt_d = (state_q == FLUSH) ? flush_cnt_q + 1'b1 : '0;

  //////////////////////////////////////////////////////////////////////
  // replacement
  //////////////////////////////////////////////////////////////////////

  // lowest invalid way of the looked up set
  always_comb begin
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!vld_rdata_i[w]) begin
        inv_way = way_idx_t'(w);
      end
    end
  end

  assign all_valid    = &vld_rdata_i;
  assign repl_capture = (state_q == LOOKUP) & ~hit_i;

  // one-hot write mask from the chosen way
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      wr_way_mask_o[w] = (repl_way_q == way_idx_t'(w));
    end
  end

  // fibonacci lfsr, x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb   = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  // only advance when a full set gets a line
  assign lfsr_step = wr_en_o & all_valid_q;

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      repl_way_q  <= '0;
      all_valid_q <= 1'b0;
      lfsr_q      <= {{(LFSR_W-1){1'b0}}, 1'b1};
    end else begin
      state_q     <= state_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
      if (repl_capture) begin
        repl_way_q  <= all_valid ? lfsr_q[0] : inv_way;
        all_valid_q <= all_valid;
      end
      if (lfsr_step) begin
        lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_fb};
      end
    end
  end

  // fetch address is held for the whole lookup and refill
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q <= req_addr_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/icache_arrays.sv
// instruction cache tag and data arrays

`timescale 1ns/1ps
`default_nettype none

module icache_arrays import icache_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      rd_en_i,
  input  wire logic      wr_en_i,
  input  wire logic      vld_clr_en_i,
  input  wire index_t    index_i,
  input  wire way_mask_t wr_way_mask_i,
  input  wire tag_t      wr_tag_i,
  input  wire line_t     wr_line_i,
  output tag_t           tag_rdata_o  [NUM_WAYS],
  output way_mask_t      vld_rdata_o,
  output line_t          line_rdata_o [NUM_WAYS]
);

  // storage, one entry per set and way
  tag_t      tag_mem  [NUM_WAYS][NUM_SETS];
  line_t     line_mem [NUM_WAYS][NUM_SETS];
  // valid bits per set, one bit per way
  way_mask_t vld_q    [NUM_SETS];

  //////////////////////////////////////////////////////////////////////
  // tag and line storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      // write only the selected way
      if (wr_en_i && wr_way_mask_i[w]) begin
        tag_mem[w][index_i]  <= wr_tag_i;
        line_mem[w][index_i] <= wr_line_i;
      end
      // all ways are read out together
      if (rd_en_i) begin
        tag_rdata_o[w]  <= tag_mem[w][index_i];
        line_rdata_o[w] <= line_mem[w][index_i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // valid bits
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        vld_q[s] <= '0;
      end
      vld_rdata_o <= '0;
    end else begin
      // clearing drops every way of the set
      if (vld_clr_en_i) begin
        vld_q[index_i] <= '0;
      end else if (wr_en_i) begin
        vld_q[index_i] <= vld_q[index_i] | wr_way_mask_i;
      end
      if (rd_en_i) begin
        vld_rdata_o <= vld_q[index_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/icache_hit_select.sv
// instruction cache hit and word select

`timescale 1ns/1ps
`default_nettype none

module icache_hit_select import icache_pkg::*; (
  input  wire tag_t      tag_rdata_i  [NUM_WAYS],
  input  wire way_mask_t vld_rdata_i,
  input  wire line_t     line_rdata_i [NUM_WAYS],
  input  wire tag_t      lookup_tag_i,
  input  wire word_sel_t lookup_word_i,
  input  wire logic      use_refill_i,
  input  wire line_t     refill_line_i,
  output logic           hit_o,
  output fetch_word_t    rsp_data_o
);

  way_mask_t hit_vec;
  way_idx_t  hit_way;
  line_t     sel_line;

  //////////////////////////////////////////////////////////////////////
  // tag compare
  //////////////////////////////////////////////////////////////////////

  // a stale tag never hits, valid qualifies the compare
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = vld_rdata_i[w] & (tag_rdata_i[w] == lookup_tag_i);
    end
  end

  assign hit_o = |hit_vec;

  // lowest hitting way, a line lives in one way only
  always_comb begin
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = way_idx_t'(w);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // word select
  //////////////////////////////////////////////////////////////////////

  // refill data bypasses the arrays when a miss completes
  assign sel_line   = use_refill_i ? refill_line_i : line_rdata_i[hit_way];
  assign rsp_data_o = sel_line[lookup_word_i * FETCH_W +: FETCH_W];

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
// instruction cache top level

`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  // fetch
  input  wire logic   req_valid_i,
  input  wire addr_t  req_addr_i,
  output logic        busy_o,
  // response
  output logic        rsp_valid_o,
  output fetch_word_t rsp_data_o,
  output logic        miss_o,
  // memory request and return
  output logic        mem_req_o,
  output addr_t       mem_addr_o,
  input  wire logic   mem_rtrn_valid_i,
  input  wire line_t  mem_rtrn_data_i,
  // maintenance
  input  wire logic   flush_i,
  input  wire logic   inv_valid_i,
  input  wire index_t inv_index_i
);

  // controller to arrays
  logic      rd_en;
  logic      wr_en;
  logic      vld_clr_en;
  index_t    arr_index;
  way_mask_t wr_way_mask;
  tag_t      wr_tag;

  // array read data
  tag_t      tag_rdata  [NUM_WAYS];
  way_mask_t vld_rdata;
  line_t     line_rdata [NUM_WAYS];

  // lookup context and hit result
  tag_t      lookup_tag;
  word_sel_t lookup_word;
  logic      use_refill;
  logic      hit;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  icache_ctrl i_ctrl (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .req_valid_i      ( req_valid_i      ),
    .req_addr_i       ( req_addr_i       ),
    .busy_o           ( busy_o           ),
    .rsp_valid_o      ( rsp_valid_o      ),
    .miss_o           ( miss_o           ),
    .mem_req_o        ( mem_req_o        ),
    .mem_addr_o       ( mem_addr_o       ),
    .mem_rtrn_valid_i ( mem_rtrn_valid_i ),
    .flush_i          ( flush_i          ),
    .inv_valid_i      ( inv_valid_i      ),
    .inv_index_i      ( inv_index_i      ),
    .hit_i            ( hit              ),
    .vld_rdata_i      ( vld_rdata        ),
    .rd_en_o          ( rd_en            ),
    .wr_en_o          ( wr_en            ),
    .vld_clr_en_o     ( vld_clr_en       ),
    .arr_index_o      ( arr_index        ),
    .wr_way_mask_o    ( wr_way_mask      ),
    .wr_tag_o         ( wr_tag           ),
    .lookup_tag_o     ( lookup_tag       ),
    .lookup_word_o    ( lookup_word      ),
    .use_refill_o     ( use_refill       )
  );

  //////////////////////////////////////////////////////////////////////
  // storage and hit stage
  //////////////////////////////////////////////////////////////////////

  // refill line is written straight from the memory return
  icache_arrays i_arrays (
    .clk_i         ( clk_i           ),
    .rst_ni        ( rst_ni          ),
    .rd_en_i       ( rd_en           ),
    .wr_en_i       ( wr_en           ),
    .vld_clr_en_i  ( vld_clr_en      ),
    .index_i       ( arr_index       ),
    .wr_way_mask_i ( wr_way_mask     ),
    .wr_tag_i      ( wr_tag          ),
    .wr_line_i     ( mem_rtrn_data_i ),
    .tag_rdata_o   ( tag_rdata       ),
    .vld_rdata_o   ( vld_rdata       ),
    .line_rdata_o  ( line_rdata      )
  );

  icache_hit_select i_hit_select (
    .tag_rdata_i   ( tag_rdata       ),
    .vld_rdata_i   ( vld_rdata       ),
    .line_rdata_i  ( line_rdata      ),
    .lookup_tag_i  ( lookup_tag      ),
    .lookup_word_i ( lookup_word     ),
    .use_refill_i  ( use_refill      ),
    .refill_line_i ( mem_rtrn_data_i ),
    .hit_o         ( hit             ),
    .rsp_data_o    ( rsp_data_o      )
  );

endmodule

`default_nettype wire

// File: verification/icache_props.sv
// controller assertions

`timescale 1ns/1ps
`default_nettype none

module icache_props import icache_pkg::*; (
  input wire logic        clk_i,
  input wire logic        rst_ni,
  input wire ctrl_state_e state_i,
  input wire logic        wr_en_i,
  input wire logic        vld_clr_en_i,
  input wire logic        mem_req_i,
  input wire logic        mem_rtrn_valid_i
);

  // a line request stays out until memory returns it
  logic outstanding_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (mem_req_i) begin
      outstanding_q <= 1'b1;
    end else if (mem_rtrn_valid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i inside {FLUSH, IDLE, LOOKUP, REFILL})
    else $error("controller state out of range");

  // a set is either written or cleared, never both
  wr_clr_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wr_en_i && vld_clr_en_i))
    else $error("line write and valid clear in the same cycle");

  single_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i |-> !outstanding_q)
    else $error("second memory request before the return");

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
// testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held low over two rising edges
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/tb_icache.sv
// instruction cache testbench

`timescale 1ns/1ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

  //////////////////////////////////////////////////////////////////////
  // constants and signals
  //////////////////////////////////////////////////////////////////////

  // word k of a line is the line word address plus k xored with this constant
  localparam logic [31:0] RULE_XOR = 32'h5a3c_0f96;
  localparam logic [31:0] SEED     = 32'hb94e_ce9d;
  localparam int CYCLES_PER_ENTRY  = 40;
  localparam int NUM_RANDOM        = 10;
  // entry kinds where a pair is two back-to-back hits
  localparam int K_FETCH = 0;
  localparam int K_INV   = 1;
  localparam int K_FLUSH = 2;
  localparam int K_PAIR  = 3;
  localparam int MISS_NO  = 0;
  localparam int MISS_YES = 1;
  localparam int MISS_ANY = 2;
  // tags 0x10, 0x20, 0x30 in sets 4 and 8
  localparam addr_t ADDR_A = 32'h0000_1040;
  localparam addr_t ADDR_B = 32'h0000_2040;
  localparam addr_t ADDR_C = 32'h0000_3040;
  localparam addr_t ADDR_D = 32'h0000_1080;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  addr_t       req_addr;
  logic        busy;
  logic        rsp_valid;
  fetch_word_t rsp_data;
  logic        miss;
  logic        mem_req;
  addr_t       mem_addr;
  logic        rtrn_valid;
  line_t       rtrn_data;
  logic        flush;
  logic        inv_valid;
  index_t      inv_index;

  int          kind_q[$];
  addr_t       addr_q[$];
  int          miss_q[$];
  logic [31:0] lfsr_q;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  icache_top i_dut (
    .clk_i(clk), .rst_ni(rst_n),
    .req_valid_i(req_valid), .req_addr_i(req_addr), .busy_o(busy),
    .rsp_valid_o(rsp_valid), .rsp_data_o(rsp_data), .miss_o(miss),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr),
    .mem_rtrn_valid_i(rtrn_valid), .mem_rtrn_data_i(rtrn_data),
    .flush_i(flush), .inv_valid_i(inv_valid), .inv_index_i(inv_index)
  );

  bind icache_ctrl icache_props i_props (
    .clk_i(clk_i), .rst_ni(rst_ni), .state_i(state_q),
    .wr_en_i(wr_en_o), .vld_clr_en_i(vld_clr_en_o),
    .mem_req_i(mem_req_o), .mem_rtrn_valid_i(mem_rtrn_valid_i)
  );

  //////////////////////////////////////////////////////////////////////
  // reference rule, random bits, checking
  //////////////////////////////////////////////////////////////////////

  function automatic fetch_word_t rule_word(input addr_t a);
    return (a >> 2) ^ RULE_XOR;
  endfunction

  function automatic line_t rule_line(input addr_t line_addr);
    line_t l;
    for (int k = 0; k < LINE_W / FETCH_W; k++) begin
      l[k*FETCH_W +: FETCH_W] = ((line_addr >> 2) + 32'(k)) ^ RULE_XOR;
    end
    return l;
  endfunction

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      fail_now($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic add_entry(input int kind, input addr_t addr, input int exp_miss);
    kind_q.push_back(kind);
    addr_q.push_back(addr);
    miss_q.push_back(exp_miss);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic wait_idle();
    @(negedge clk);
    while (busy) @(negedge clk);
  endtask

  task automatic run_fetch(input string name, input addr_t addr, input int exp_miss);
    int lat;
    int saw_miss;
    lat = 0;
    saw_miss = 0;
    wait_idle();
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr  <= addr;
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    while (!rsp_valid) begin
      if (mem_req) begin
        saw_miss = 1;
        check({name, " miss strobe"}, 32'd1, 32'(miss));
        check({name, " line address"}, {addr[31:4], 4'h0}, mem_addr);
      end
      lat++;
      @(negedge clk);
    end
    check({name, " data"}, rule_word(addr), rsp_data);
    // no new line request goes out with a response
    check({name, " rsp mem_req"}, 32'd0, 32'(mem_req));
    check({name, " rsp miss"}, 32'd0, 32'(miss));
    if (exp_miss != MISS_ANY) check({name, " miss"}, 32'(exp_miss), 32'(saw_miss));
    if (exp_miss == MISS_NO) check({name, " hit latency"}, 32'd0, 32'(lat));
  endtask

  // second fetch is issued in the response cycle of the first
  task automatic run_pair(input string name, input addr_t addr);
    wait_idle();
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr  <= addr;
    @(posedge clk);
    req_addr  <= addr + 32'd4;
    @(negedge clk);
    check({name, " first valid"}, 32'd1, 32'(rsp_valid));
    check({name, " first data"}, rule_word(addr), rsp_data);
    check({name, " busy"}, 32'd0, 32'(busy));
    check({name, " first req"}, 32'd0, 32'(mem_req));
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    check({name, " second valid"}, 32'd1, 32'(rsp_valid));
    check({name, " second data"}, rule_word(addr + 32'd4), rsp_data);
    check({name, " second req"}, 32'd0, 32'(mem_req));
  endtask

  task automatic run_invalidate(input index_t idx);
    wait_idle();
    @(posedge clk);
    inv_valid <= 1'b1;
    inv_index <= idx;
    @(posedge clk);
    inv_valid <= 1'b0;
  endtask

  // strobe cycle plus one cycle per set
  task automatic run_flush(input string name);
    int cnt;
    wait_idle();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    cnt = 1;
    @(negedge clk);
    while (busy) begin
      cnt++;
      @(negedge clk);
    end
    check({name, " flush cycles"}, 32'(NUM_SETS + 1), 32'(cnt));
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory model and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    addr_t line_addr;
    rtrn_valid = 1'b0;
    rtrn_data  = '0;
    forever begin
      @(negedge clk);
      if (mem_req) begin
        line_addr = mem_addr;
        repeat (3) @(posedge clk);
        rtrn_valid <= 1'b1;
        rtrn_data  <= rule_line(line_addr);
        @(posedge clk);
        rtrn_valid <= 1'b0;
      end
    end
  end

  initial begin
    int limit;
    @(posedge rst_n);
    limit = (kind_q.size() + 1) * CYCLES_PER_ENTRY;
    repeat (limit) @(posedge clk);
    fail_now($sformatf("watchdog expired after %0d cycles", limit));
  end

  //////////////////////////////////////////////////////////////////////
  // table and main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    string name;
    int    busy_cycles;
    int    t;
    int    s;
    int    w;
    addr_t ra;
    req_valid = 1'b0;
    req_addr  = '0;
    flush     = 1'b0;
    inv_valid = 1'b0;
    inv_index = '0;
    lfsr_q    = SEED;
    // cold miss, hits in the line, two tags in one set
    add_entry(K_FETCH, ADDR_A, MISS_YES);
    add_entry(K_FETCH, ADDR_A + 32'h8, MISS_NO);
    add_entry(K_PAIR,  ADDR_A + 32'h4, MISS_NO);
    add_entry(K_FETCH, ADDR_B, MISS_YES);
    add_entry(K_FETCH, ADDR_B + 32'hc, MISS_NO);
    add_entry(K_FETCH, ADDR_A, MISS_NO);
    add_entry(K_FETCH, ADDR_B + 32'h4, MISS_NO);
    add_entry(K_FETCH, ADDR_D, MISS_YES);
    // set 4 dropped, set 8 kept
    add_entry(K_INV,   ADDR_A, MISS_ANY);
    add_entry(K_FETCH, ADDR_A + 32'h4, MISS_YES);
    add_entry(K_FETCH, ADDR_D + 32'h8, MISS_NO);
    add_entry(K_FETCH, ADDR_B, MISS_YES);
    add_entry(K_FLUSH, ADDR_A, MISS_ANY);
    add_entry(K_FETCH, ADDR_A, MISS_YES);
    add_entry(K_FETCH, ADDR_D, MISS_YES);
    add_entry(K_FETCH, ADDR_B, MISS_YES);
    // third tag into a full set
    add_entry(K_FETCH, ADDR_C, MISS_YES);
    add_entry(K_FETCH, ADDR_C + 32'h4, MISS_NO);
    add_entry(K_PAIR,  ADDR_C + 32'h8, MISS_NO);
    for (int r = 0; r < NUM_RANDOM; r++) begin
      t  = take_bits(2) % 3;
      s  = take_bits(1);
      w  = take_bits(2);
      ra = addr_t'((t + 1) * 'h1000 + (s + 1) * 'h40 + w * 4);
      add_entry(K_FETCH, ra, MISS_ANY);
      add_entry(K_FETCH, ra, MISS_NO);
    end

    // reset flush walks all sets
    @(posedge rst_n);
    busy_cycles = 0;
    @(negedge clk);
    while (busy) begin
      check("reset rsp_valid", 32'd0, 32'(rsp_valid));
      check("reset mem_req", 32'd0, 32'(mem_req));
      check("reset miss", 32'd0, 32'(miss));
      busy_cycles++;
      @(negedge clk);
    end
    check("reset flush cycles", 32'(NUM_SETS), 32'(busy_cycles));

    for (int i = 0; i < kind_q.size(); i++) begin
      name = $sformatf("entry %0d addr %h", i, addr_q[i]);
      case (kind_q[i])
        K_FETCH: run_fetch(name, addr_q[i], miss_q[i]);
        K_PAIR:  run_pair(name, addr_q[i]);
        K_INV:   run_invalidate(addr_q[i][OFFSET_W +: INDEX_W]);
        K_FLUSH: run_flush(name);
        default: fail_now($sformatf("unknown table entry kind at entry %0d", i));
      endcase
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rtl/icache_pkg.sv
rtl/icache_ctrl.sv
rtl/icache_arrays.sv
rtl/icache_hit_select.sv
rtl/icache_top.sv
verification/icache_props.sv
verification/tb_clk_gen.sv
verification/tb_icache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the instruction cache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_icache -f src.f

# the log decides the result, not the exit status of the pipe
./obj_dir/Vtb_icache 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
